// ==== cache_bank/cache_bank.sv ====
`timescale 1ns/1ps

module cache_bank #(
	parameter int ENTRY_BITS = 9,
	parameter int BANK_BITS = 2
) (
	input  logic                   I_clk,
	input  logic                   rst_n,
	input  logic                   advance,
	input  logic                   sel,
	input  cache_pkg::bank_req_t   bank_req,
	output logic                   init_done,
	output logic                   resp_valid,
	output cache_pkg::cache_resp_t resp
);

	// each bank holds the entries whose low index bits match its number
	localparam int LOCAL_BITS = ENTRY_BITS - BANK_BITS;
	localparam int DEPTH = 2**LOCAL_BITS;

	typedef struct packed {
		logic            valid;
		cache_pkg::tag_t tag;
	} tag_entry_t;

	tag_entry_t     tag_mem  [DEPTH];
	bus_pkg::word_t data_mem [DEPTH];

	cache_pkg::sweep_state_t state;
	logic [LOCAL_BITS-1:0]   sweep_cnt;

	logic [LOCAL_BITS-1:0] slot;
	logic                  running;
	logic                  do_req;
	logic                  is_read;
	logic                  is_fill;
	logic                  fill_en;
	logic                  inval_en;
	tag_entry_t            cur_entry;
	logic                  lookup_hit;
	logic                  tag_we;
	logic [LOCAL_BITS-1:0] tag_addr;
	tag_entry_t            tag_wdata;

	// the bank number bits are dropped, they are the same for every entry here
	assign slot = bank_req.index[ENTRY_BITS-1:BANK_BITS];

	assign running = (state == cache_pkg::st_run);
	assign init_done = running;

	assign do_req = running && sel && advance;
	assign is_read = (bank_req.op == bus_pkg::op_read);
	assign is_fill = (bank_req.op == bus_pkg::op_fill);
	assign fill_en = do_req && is_fill && bank_req.cacheable;
	assign inval_en = do_req && bank_req.invalidate;

	// an uncacheable read never hits, even if the tag bits happen to match
	assign cur_entry = tag_mem[slot];
	assign lookup_hit = is_read && bank_req.cacheable && cur_entry.valid &&
		(cur_entry.tag == bank_req.tag);

	// single tag write port shared by the sweep, fills and snoop invalidation
	assign tag_we = !running || fill_en || inval_en;
	assign tag_addr = running ? slot : sweep_cnt;

	always_comb begin
		tag_wdata = '0;
		if (fill_en) begin
			tag_wdata.valid = 1'b1;
			tag_wdata.tag = bank_req.tag;
		end
	end

	// sweep clears one entry per cycle, then the bank goes live for good
	always_ff @(posedge I_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cache_pkg::st_sweep;
			sweep_cnt <= '0;
		end else if (!running) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (&sweep_cnt)
				state <= cache_pkg::st_run;
		end
	end

	always_ff @(posedge I_clk) begin
		if (tag_we)
			tag_mem[tag_addr] <= tag_wdata;
		if (fill_en)
			data_mem[slot] <= bank_req.data;
	end

	always_ff @(posedge I_clk or negedge rst_n) begin
		if (!rst_n)
			resp_valid <= 1'b0;
		else if (advance)
			resp_valid <= running && sel;
	end

	// response payload holds while the pipeline is stalled
	always_ff @(posedge I_clk) begin
		if (do_req) begin
			resp.op <= bank_req.op;
			resp.hit <= lookup_hit;
			// misses and non-reads return zero data
			resp.data <= lookup_hit ? data_mem[slot] : '0;
		end
	end

endmodule

// ==== common/bus_pkg.sv ====
package bus_pkg;

	// widths of the CPU memory bus
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// byte address as seen on the bus
	typedef logic [ADDR_W-1:0] addr_t;

	// one data word as transferred on the bus
	typedef logic [WORD_W-1:0] word_t;

	// bus operations a request can carry
	// a fill offers a word that was read from memory, the cache decides whether it keeps it
	// the three writes only matter to the cache as snoops that invalidate an entry
	typedef enum logic [2:0] {
		op_read    = 3'd0,
		op_fill    = 3'd1,
		op_write_b = 3'd2,
		op_write_h = 3'd3,
		op_write_w = 3'd4
	} bus_op_t;

endpackage

// ==== common/cache_pkg.sv ====
package cache_pkg;

	// tag width is fixed, the index width follows ENTRY_BITS of the top level
	localparam int TAG_W = 15;

	// index fields are carried at their widest, a bank only looks at the low ENTRY_BITS bits
	localparam int INDEX_MAX_W = 16;

	// address tag without the valid bit
	typedef logic [TAG_W-1:0] tag_t;

	// entry index of the whole cache, zero extended
	typedef logic [INDEX_MAX_W-1:0] index_t;

	// request as it arrives from the CPU side
	typedef struct packed {
		bus_pkg::bus_op_t op;
		bus_pkg::addr_t   addr;
		// only meaningful for a fill
		bus_pkg::word_t   data;
	} cache_req_t;

	// decoded request handed from the dispatcher to the banks
	typedef struct packed {
		bus_pkg::bus_op_t op;
		tag_t             tag;
		index_t           index;
		bus_pkg::word_t   data;
		logic             cacheable;
		logic             invalidate;
	} bank_req_t;

	// one response per request, op is echoed back
	typedef struct packed {
		bus_pkg::bus_op_t op;
		logic             hit;
		bus_pkg::word_t   data;
	} cache_resp_t;

	// a bank first clears its valid bits, then serves requests
	typedef enum logic {
		st_sweep = 1'b0,
		st_run   = 1'b1
	} sweep_state_t;

endpackage

// ==== compile.f ====
common/bus_pkg.sv
common/cache_pkg.sv
source/req_dispatch.sv
cache_bank/cache_bank.sv
source/resp_collect.sv
source/cache_subsystem.sv
testbench/cache_subsystem_checker.sv
testbench/cache_scoreboard.sv
testbench/tb_cache_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_subsystem -f compile.f

out=$(./obj_dir/Vtb_cache_subsystem +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

// ==== source/cache_subsystem.sv ====
`timescale 1ns/1ps

module cache_subsystem #(
	parameter int ENTRY_BITS = 9,
	parameter int BANK_BITS = 2
) (
	input  logic                   I_clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  cache_pkg::cache_req_t  req,
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output cache_pkg::cache_resp_t resp
);

	localparam int NUM_BANKS = 2**BANK_BITS;

	cache_pkg::bank_req_t   bank_req;
	logic [NUM_BANKS-1:0]   bank_sel;
	logic [NUM_BANKS-1:0]   bank_resp_valid;
	cache_pkg::cache_resp_t bank_resp [NUM_BANKS];
	logic [NUM_BANKS-1:0]   init_done;
	logic                   ready_gate;
	logic                   advance;

	// requests wait until every bank has finished clearing its valid bits
	assign ready_gate = &init_done;

	req_dispatch #(
		.ENTRY_BITS (ENTRY_BITS),
		.BANK_BITS  (BANK_BITS)
	) u_dispatch (
		.I_clk      (I_clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req        (req),
		.ready_gate (ready_gate),
		.advance    (advance),
		.bank_req   (bank_req),
		.bank_sel   (bank_sel)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		cache_bank #(
			.ENTRY_BITS (ENTRY_BITS),
			.BANK_BITS  (BANK_BITS)
		) u_bank (
			.I_clk      (I_clk),
			.rst_n      (rst_n),
			.advance    (advance),
			.sel        (bank_sel[b]),
			.bank_req   (bank_req),
			.init_done  (init_done[b]),
			.resp_valid (bank_resp_valid[b]),
			.resp       (bank_resp[b])
		);
	end

	resp_collect #(
		.BANK_BITS (BANK_BITS)
	) u_collect (
		.bank_resp_valid (bank_resp_valid),
		.bank_resp       (bank_resp),
		.resp_valid      (resp_valid),
		.resp_ready      (resp_ready),
		.resp            (resp),
		.advance         (advance)
	);

endmodule

// ==== source/req_dispatch.sv ====
`timescale 1ns/1ps

module req_dispatch #(
	parameter int ENTRY_BITS = 9,
	parameter int BANK_BITS = 2,
	localparam int NUM_BANKS = 2**BANK_BITS
) (
	input  logic                   I_clk,
	input  logic                   rst_n,
	input  logic                   req_valid,
	output logic                   req_ready,
	input  cache_pkg::cache_req_t  req,
	input  logic                   ready_gate,
	input  logic                   advance,
	output cache_pkg::bank_req_t   bank_req,
	output logic [NUM_BANKS-1:0]   bank_sel
);

	// address fields, index sits right above the byte offset and the tag right above the index
	localparam int IDX_LO = 2;
	localparam int IDX_HI = ENTRY_BITS + 1;
	localparam int TAG_LO = IDX_HI + 1;
	localparam int TAG_HI = IDX_HI + cache_pkg::TAG_W;

	logic                 accept;
	logic                 in_range;
	logic                 is_write;
	logic [BANK_BITS-1:0] bank;
	cache_pkg::bank_req_t dec_req;

	// the pipeline only takes a new request when every bank is swept and nothing is stalled
	assign req_ready = ready_gate && advance;
	assign accept = req_valid && req_ready;

	// anything above the tag has to be zero, otherwise the address aliases with a cached one
	assign in_range = (req.addr[bus_pkg::ADDR_W-1:TAG_HI+1] == '0);

	assign is_write = (req.op == bus_pkg::op_write_b) ||
		(req.op == bus_pkg::op_write_h) ||
		(req.op == bus_pkg::op_write_w);

	always_comb begin
		dec_req.op = req.op;
		dec_req.tag = req.addr[TAG_HI:TAG_LO];
		dec_req.index = cache_pkg::index_t'(req.addr[IDX_HI:IDX_LO]);
		dec_req.data = req.data;
		dec_req.cacheable = in_range && (req.addr[1:0] == 2'b00);
		// writes snoop on the index only, the tag is not compared
		dec_req.invalidate = is_write && in_range;
	end

	// interleave banks on the low bits of the index
	assign bank = dec_req.index[BANK_BITS-1:0];

	always_ff @(posedge I_clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_sel <= '0;
		end else if (advance) begin
			if (accept)
				bank_sel <= NUM_BANKS'(1) << bank;
			else
				bank_sel <= '0;
		end
	end

	// payload only moves with an accepted request
	always_ff @(posedge I_clk) begin
		if (accept)
			bank_req <= dec_req;
	end

endmodule

// ==== source/resp_collect.sv ====
`timescale 1ns/1ps

module resp_collect #(
	parameter int BANK_BITS = 2,
	localparam int NUM_BANKS = 2**BANK_BITS
) (
	input  logic [NUM_BANKS-1:0]   bank_resp_valid,
	input  cache_pkg::cache_resp_t bank_resp [NUM_BANKS],
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output cache_pkg::cache_resp_t resp,
	output logic                   advance
);

	// at most one bank holds a response, requests enter one at a time and
	// every bank has the same latency
	assign resp_valid = |bank_resp_valid;

	always_comb begin
		resp = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (bank_resp_valid[i])
				resp = bank_resp[i];
		end
	end

	// a response waiting on the output freezes every stage behind it
	assign advance = !(resp_valid && !resp_ready);

endmodule

// ==== testbench/cache_scoreboard.sv ====
`timescale 1ns/1ps

module cache_scoreboard #(
	parameter int ENTRY_BITS = 9
) (
	input logic                   I_clk,
	input logic                   rst_n,
	input logic                   req_valid,
	input logic                   req_ready,
	input cache_pkg::cache_req_t  req,
	input logic                   resp_valid,
	input logic                   resp_ready,
	input cache_pkg::cache_resp_t resp
);

	localparam int NUM_ENTRIES = 2**ENTRY_BITS;

	// reference copy of the whole cache, indexed by the full entry index
	logic            model_valid [NUM_ENTRIES];
	cache_pkg::tag_t model_tag   [NUM_ENTRIES];
	bus_pkg::word_t  model_data  [NUM_ENTRIES];

	// accepted requests waiting for their response, oldest first
	cache_pkg::cache_req_t pending [$];

	int accepted_count;
	int resp_count;
	int check_count;
	int err_count;

	task automatic check_response();
		cache_pkg::cache_req_t exp_req;
		logic [ENTRY_BITS-1:0] idx;
		cache_pkg::tag_t       tag;
		logic                  in_range;
		logic                  cacheable;
		logic                  exp_hit;
		bus_pkg::word_t        exp_data;
		string                 msg;
		exp_req = pending.pop_front();
		idx = ENTRY_BITS'(exp_req.addr >> 2);
		tag = cache_pkg::tag_t'(exp_req.addr >> (ENTRY_BITS + 2));
		in_range = (exp_req.addr >> (ENTRY_BITS + 17)) == 0;
		cacheable = in_range && (exp_req.addr[1:0] == 2'b00);
		exp_hit = 1'b0;
		exp_data = '0;
		case (exp_req.op)
			bus_pkg::op_read: begin
				exp_hit = cacheable && model_valid[idx] && (model_tag[idx] == tag);
				if (exp_hit)
					exp_data = model_data[idx];
			end
			bus_pkg::op_fill: begin
				if (cacheable) begin
					model_valid[idx] = 1'b1;
					model_tag[idx] = tag;
					model_data[idx] = exp_req.data;
				end
			end
			default: begin
				// a write drops whatever sits at its index, the tag is not compared
				if (in_range)
					model_valid[idx] = 1'b0;
			end
		endcase
		check_count++;
		if (resp.op !== exp_req.op || resp.hit !== exp_hit ||
			(exp_hit && resp.data !== exp_data)) begin
			msg = $sformatf("%s addr %h expected hit %0b data %h", exp_req.op.name(),
				exp_req.addr, exp_hit, exp_data);
			msg = {msg, $sformatf(", got op %0d hit %0b data %h", resp.op, resp.hit, resp.data)};
			$display("FAILED at time %0t: %s", $time, msg);
			err_count++;
		end
	endtask

	always @(posedge I_clk or negedge rst_n) begin
		if (!rst_n) begin
			pending.delete();
			for (int i = 0; i < NUM_ENTRIES; i++)
				model_valid[i] = 1'b0;
			accepted_count = 0;
			resp_count = 0;
			check_count = 0;
			err_count = 0;
		end else begin
			if (resp_valid && resp_ready) begin
				resp_count++;
				if (pending.size() == 0) begin
					$display("FAILED at time %0t: response without an outstanding request",
						$time);
					err_count++;
				end else begin
					check_response();
				end
			end
			if (req_valid && req_ready) begin
				pending.push_back(req);
				accepted_count++;
			end
		end
	end

endmodule

// ==== testbench/cache_subsystem_checker.sv ====
`timescale 1ns/1ps

module cache_subsystem_checker #(
	parameter int ENTRY_BITS = 9,
	parameter int BANK_BITS = 2
) (
	input logic                   I_clk,
	input logic                   rst_n,
	input logic                   req_valid,
	input logic                   req_ready,
	input logic                   resp_valid,
	input logic                   resp_ready,
	input cache_pkg::cache_resp_t resp
);

	// each bank clears one entry per cycle after reset
	localparam int SWEEP_CYCLES = 2**(ENTRY_BITS - BANK_BITS);

	int   since_reset;
	logic accepted_q;
	int   fail_count = 0;

	always_ff @(posedge I_clk or negedge rst_n) begin
		if (!rst_n) begin
			since_reset <= 0;
			accepted_q <= 1'b0;
		end else begin
			if (since_reset < SWEEP_CYCLES)
				since_reset <= since_reset + 1;
			accepted_q <= req_valid && req_ready;
		end
	end

	a_idle_in_reset: assert property (@(posedge I_clk) !rst_n |-> !req_ready && !resp_valid)
		else begin
			$error("req_ready or resp_valid high during reset");
			fail_count++;
		end

	a_closed_in_sweep: assert property (@(posedge I_clk) disable iff (!rst_n)
		since_reset < SWEEP_CYCLES |-> !req_ready)
		else begin
			$error("req_ready high before the bank sweep ended");
			fail_count++;
		end

	// a stalled response has to wait on the port unchanged
	a_resp_held: assert property (@(posedge I_clk) disable iff (!rst_n)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp))
		else begin
			$error("response changed or dropped while stalled");
			fail_count++;
		end

	a_two_cycle_latency: assert property (@(posedge I_clk) disable iff (!rst_n)
		accepted_q && resp_ready |=> resp_valid)
		else begin
			$error("response missing two cycles after acceptance");
			fail_count++;
		end

endmodule

// ==== testbench/tb_cache_subsystem.sv ====
`timescale 1ns/1ps

module tb_cache_subsystem;

	localparam int ENTRY_BITS = 9;
	localparam int BANK_BITS = 2;
	localparam int SWEEP_CYCLES = 2**(ENTRY_BITS - BANK_BITS);
	localparam int ACCEPT_TIMEOUT = 1000;
	localparam int DRAIN_TIMEOUT = 200;
	localparam int RANDOM_REQS = 400;

	logic                   I_clk;
	logic                   rst_n;
	logic                   req_valid;
	logic                   req_ready;
	cache_pkg::cache_req_t  req;
	logic                   resp_valid;
	logic                   resp_ready;
	cache_pkg::cache_resp_t resp;

	integer          seed = 32'h87b1_1222;
	logic            backpressure;
	int              tb_errors;
	int              test_num;
	int              checks_mark;
	int              errs_mark;
	time             release_time;
	// a few tags so that conflicts at one index come up often
	cache_pkg::tag_t tag_pool [4] = '{15'h0000, 15'h0001, 15'h2a5a, 15'h7fff};

	cache_subsystem #(
		.ENTRY_BITS (ENTRY_BITS),
		.BANK_BITS  (BANK_BITS)
	) UUT (
		.I_clk      (I_clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req        (req),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

	cache_scoreboard #(
		.ENTRY_BITS (ENTRY_BITS)
	) u_scoreboard (
		.I_clk      (I_clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req        (req),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

	bind cache_subsystem cache_subsystem_checker #(
		.ENTRY_BITS (ENTRY_BITS),
		.BANK_BITS  (BANK_BITS)
	) u_checker (
		.I_clk      (I_clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp       (resp)
	);

	initial begin
		I_clk = 1'b0;
		forever #4 I_clk = ~I_clk;
	end

	function automatic int total_errors();
		return u_scoreboard.err_count + tb_errors + UUT.u_checker.fail_count;
	endfunction

	function automatic bus_pkg::addr_t make_addr(input cache_pkg::tag_t tag, input int idx);
		return (bus_pkg::addr_t'(tag) << (ENTRY_BITS + 2)) | (bus_pkg::addr_t'(idx) << 2);
	endfunction

	// mostly aligned and in range, now and then out of range or unaligned
	function automatic bus_pkg::addr_t random_addr();
		bus_pkg::addr_t addr;
		addr = make_addr(tag_pool[$random(seed) & 3], ($random(seed) & 7) * 5);
		if (($random(seed) & 15) == 0)
			addr[31] = 1'b1;
		if (($random(seed) & 15) == 0)
			addr[0] = 1'b1;
		return addr;
	endfunction

	function automatic bus_pkg::bus_op_t random_op();
		int pick;
		pick = $random(seed) & 15;
		if (pick < 6)
			return bus_pkg::op_read;
		else if (pick < 11)
			return bus_pkg::op_fill;
		else if (pick < 13)
			return bus_pkg::op_write_b;
		else if (pick < 15)
			return bus_pkg::op_write_h;
		else
			return bus_pkg::op_write_w;
	endfunction

	task automatic abort_run(input string why);
		$display("timeout: %s", why);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic next_negedge();
		@(negedge I_clk);
		if (backpressure)
			resp_ready = ($random(seed) & 3) != 0;
		else
			resp_ready = 1'b1;
	endtask

	// returns right after the edge on which the request was taken
	task automatic send_request(input bus_pkg::bus_op_t op, input bus_pkg::addr_t addr,
		input bus_pkg::word_t data);
		int   waited;
		logic accepted;
		next_negedge();
		req_valid = 1'b1;
		req.op = op;
		req.addr = addr;
		req.data = data;
		waited = 0;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge I_clk);
			if (req_ready) begin
				accepted = 1'b1;
			end else begin
				waited++;
				if (waited > ACCEPT_TIMEOUT)
					abort_run($sformatf("request not accepted within %0d cycles", ACCEPT_TIMEOUT));
				next_negedge();
			end
		end
	endtask

	task automatic close_test(input string name);
		int waited;
		next_negedge();
		req_valid = 1'b0;
		waited = 0;
		while (u_scoreboard.resp_count != u_scoreboard.accepted_count) begin
			@(posedge I_clk);
			waited++;
			if (waited > DRAIN_TIMEOUT)
				abort_run($sformatf("responses still missing after %0d cycles", DRAIN_TIMEOUT));
			next_negedge();
		end
		test_num++;
		$display("test %0d %s: %0d responses checked, %0d errors", test_num, name,
			u_scoreboard.check_count - checks_mark, total_errors() - errs_mark);
		checks_mark = u_scoreboard.check_count;
		errs_mark = total_errors();
	endtask

	initial begin
		bus_pkg::addr_t addr;
		bus_pkg::addr_t other;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b1;
		backpressure = 1'b0;
		tb_errors = 0;
		test_num = 0;
		checks_mark = 0;
		errs_mark = 0;
		repeat (4) @(posedge I_clk);
		@(negedge I_clk);
		rst_n = 1'b1;
		release_time = $time;

		// the first request has to wait until every bank is swept
		send_request(bus_pkg::op_read, make_addr(tag_pool[1], 5), '0);
		if (($time - release_time) / 8 < SWEEP_CYCLES) begin
			$display("first request was accepted before the sweep ended");
			tb_errors++;
		end
		for (int i = 0; i < 8; i++)
			send_request(bus_pkg::op_read, random_addr(), '0);
		close_test("reset sweep");

		backpressure = 1'b1;
		for (int i = 0; i < 12; i++) begin
			addr = make_addr(tag_pool[i & 3], (i % 8) * 5);
			other = make_addr(tag_pool[(i + 1) & 3], (i % 8) * 5);
			send_request(bus_pkg::op_fill, addr, $random(seed));
			send_request(bus_pkg::op_read, addr, '0);
			send_request(bus_pkg::op_read, other, '0);
		end
		close_test("fill then read");

		for (int i = 0; i < 12; i++) begin
			addr = make_addr(tag_pool[i & 3], i * 3);
			other = make_addr(tag_pool[$random(seed) & 3], i * 3);
			other[1:0] = 2'($random(seed));
			send_request(bus_pkg::op_fill, addr, $random(seed));
			send_request(bus_pkg::op_read, addr, '0);
			send_request(bus_pkg::bus_op_t'(bus_pkg::op_write_b + i % 3), other, $random(seed));
			send_request(bus_pkg::op_read, addr, '0);
		end
		close_test("write invalidate");

		for (int i = 0; i < 8; i++) begin
			other = make_addr(tag_pool[i & 3], i * 7);
			addr = other;
			if (i % 2 == 0)
				addr[1:0] = 2'(i / 2 % 3 + 1);
			else
				addr[ENTRY_BITS + 2 + cache_pkg::TAG_W + i / 2] = 1'b1;
			send_request(bus_pkg::op_fill, addr, $random(seed));
			send_request(bus_pkg::op_read, addr, '0);
			// the aligned in-range alias has the same tag and index and must not see the fill
			send_request(bus_pkg::op_read, other, '0);
		end
		close_test("uncached fill");

		for (int i = 0; i < RANDOM_REQS; i++) begin
			if (($random(seed) & 7) == 0) begin
				next_negedge();
				req_valid = 1'b0;
				@(posedge I_clk);
			end
			send_request(random_op(), random_addr(), $random(seed));
		end
		close_test("random traffic");

		$display("%0d tests, %0d responses checked, %0d errors", test_num,
			u_scoreboard.check_count, total_errors());
		if (total_errors() == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
